//--- rtl/adma_macros.svh
`ifndef ADMA_MACROS_SVH
`define ADMA_MACROS_SVH

// Bus data and byte address
`define ADMA_DATA_W     32
`define ADMA_ADDR_W     32

// Transfer length is counted in beats
`define ADMA_LEN_W      16

// Pending descriptors held ahead of the mover
`define ADMA_DESC_DEPTH 4

// AXI4 burst limit in beats
`define ADMA_MAX_BURST  16

// CSR byte address
`define ADMA_CSR_ADDR_W 4

`endif

//--- rtl/adma_csr_pkg.sv
`include "adma_macros.svh"

package adma_csr_pkg;

    // Word index inside the CSR block
    typedef enum logic [1:0] {
        CTRL     = 2'd0,
        SRC_ADDR = 2'd1,
        XFER_LEN = 2'd2,
        STATUS   = 2'd3
    } csr_addr_e;

    typedef struct packed {
        logic [`ADMA_DATA_W-3:0]  rsvd;
        logic                     irq_com_msk;
        logic                     dma_en;
    } ctrl_t;

    // On write, a 1 in irq_com or trap clears that flag
    typedef struct packed {
        logic [`ADMA_DATA_W-14:0] rsvd;
        logic                     trap;
        logic                     irq_com;
        logic [2:0]               queue_level;
        logic [7:0]               done_cnt;
    } status_t;

    typedef union packed {
        ctrl_t   ctrl;
        status_t status;
    } csr_word_u;

endpackage

//--- rtl/adma_xfer_pkg.sv
`include "adma_macros.svh"

package adma_xfer_pkg;

    // One queued transfer
    typedef struct packed {
        logic [`ADMA_ADDR_W-1:0] src_addr;
        logic [`ADMA_LEN_W-1:0]  len;
    } desc_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- rtl/adma_reg_map.sv
`timescale 1ns/1ns
`include "adma_macros.svh"

module adma_reg_map (
    input  logic                              aclk,
    input  logic                              rst_i,
    input  logic                              s_wvalid_i,
    input  logic [`ADMA_CSR_ADDR_W-1:0]       s_waddr_i,
    input  adma_csr_pkg::csr_word_u           s_wdata_i,
    output logic                              s_wready_o,
    input  logic                              s_arvalid_i,
    input  logic [`ADMA_CSR_ADDR_W-1:0]       s_araddr_i,
    output logic                              s_arready_o,
    output adma_csr_pkg::csr_word_u           s_rdata_o,
    output logic                              s_rvalid_o,
    input  logic                              s_rready_i,
    output logic                              push_valid_o,
    input  logic                              push_ready_i,
    output adma_xfer_pkg::desc_t              push_desc_o,
    input  logic [$clog2(`ADMA_DESC_DEPTH):0] queue_level_i,
    input  logic                              xfer_done_i,
    input  logic                              rd_err_i,
    output logic                              dma_en_o,
    output logic                              irq_o,
    output logic                              trap_o
);
    import adma_csr_pkg::*;

    csr_addr_e                wr_idx;
    csr_addr_e                rd_idx;
    logic                     wr_hs;
    logic                     sts_wr;
    logic                     ar_hs;
    ctrl_t                    ctrl_q;
    logic [`ADMA_ADDR_W-1:0]  src_addr_q;
    logic [7:0]               done_cnt_q;
    logic                     irq_pend_q;
    logic                     trap_q;
    logic                     irq_q;
    logic                     rvalid_q;
    csr_word_u                rd_word;
    csr_word_u                rdata_q;

    // Byte offset bits are ignored
    assign wr_idx = csr_addr_e'(s_waddr_i[3:2]);
    assign rd_idx = csr_addr_e'(s_araddr_i[3:2]);

    // Length writes wait for room in the queue
    assign s_wready_o   = (wr_idx != XFER_LEN) || push_ready_i;
    assign wr_hs        = s_wvalid_i && s_wready_o;
    assign sts_wr       = wr_hs && (wr_idx == STATUS);
    assign push_valid_o = s_wvalid_i && (wr_idx == XFER_LEN);

    assign push_desc_o.src_addr = src_addr_q;
    assign push_desc_o.len      = s_wdata_i[`ADMA_LEN_W-1:0];

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            ctrl_q     <= '0;
            done_cnt_q <= '0;
            irq_pend_q <= 1'b0;
            trap_q     <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            if (wr_hs && wr_idx == CTRL) begin
                ctrl_q.dma_en      <= s_wdata_i.ctrl.dma_en;
                ctrl_q.irq_com_msk <= s_wdata_i.ctrl.irq_com_msk;
            end
            // A new event wins over a clear in the same cycle
            if (xfer_done_i) begin
                done_cnt_q <= done_cnt_q + 8'd1;
                irq_pend_q <= 1'b1;
            end else if (sts_wr && s_wdata_i.status.irq_com) begin
                irq_pend_q <= 1'b0;
            end
            if (rd_err_i) begin
                trap_q <= 1'b1;
            end else if (sts_wr && s_wdata_i.status.trap) begin
                trap_q <= 1'b0;
            end
            irq_q <= irq_pend_q && ctrl_q.irq_com_msk;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_hs && wr_idx == SRC_ADDR) begin
            src_addr_q <= s_wdata_i;
        end
    end

    // XFER_LEN is write only
    always_comb begin
        rd_word = '0;
        case (rd_idx)
            CTRL:     rd_word.ctrl = ctrl_q;
            SRC_ADDR: rd_word = src_addr_q;
            STATUS: begin
                rd_word.status.done_cnt    = done_cnt_q;
                rd_word.status.queue_level = queue_level_i;
                rd_word.status.irq_com     = irq_pend_q;
                rd_word.status.trap        = trap_q;
            end
            default:  rd_word = '0;
        endcase
    end

    assign s_arready_o = !rvalid_q;
    assign ar_hs       = s_arvalid_i && s_arready_o;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;
        end else if (s_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            rdata_q <= rd_word;
        end
    end

    assign s_rvalid_o = rvalid_q;
    assign s_rdata_o  = rdata_q;
    assign dma_en_o   = ctrl_q.dma_en;
    assign irq_o      = irq_q;
    assign trap_o     = trap_q;

    a_rvalid_hold: assert property (@(posedge aclk) disable iff (rst_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

//--- rtl/adma_desc_queue.sv
`timescale 1ns/1ns
`include "adma_macros.svh"

module adma_desc_queue #(
    parameter int DEPTH = `ADMA_DESC_DEPTH
) (
    input  logic                   aclk,
    input  logic                   rst_i,
    input  logic                   push_valid_i,
    input  adma_xfer_pkg::desc_t   push_desc_i,
    output logic                   push_ready_o,
    output logic                   pop_valid_o,
    output adma_xfer_pkg::desc_t   pop_desc_o,
    input  logic                   pop_ready_i,
    output logic [$clog2(DEPTH):0] level_o
);
    import adma_xfer_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    desc_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_hs;
    logic             pop_hs;

    assign push_ready_o = (count != CNT_W'(DEPTH));
    assign pop_valid_o  = (count != '0);
    assign push_hs      = push_valid_i && push_ready_o;
    assign pop_hs       = pop_valid_o && pop_ready_i;
    assign pop_desc_o   = mem[rd_ptr];
    assign level_o      = count;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_hs) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_hs) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the level unchanged
            if (push_hs && !pop_hs) begin
                count <= count + 1'b1;
            end else if (pop_hs && !push_hs) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push_hs) begin
            mem[wr_ptr] <= push_desc_i;
        end
    end

    // A push into a full queue would carry the level past the depth
    a_no_push_full: assert property (@(posedge aclk) disable iff (rst_i)
        count <= CNT_W'(DEPTH));

    // Empty means both pointers sit on the same entry
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (rst_i)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

//--- rtl/adma_burst_mover.sv
`timescale 1ns/1ns
`include "adma_macros.svh"

module adma_burst_mover (
    input  logic                      aclk,
    input  logic                      rst_i,
    input  logic                      dma_en_i,
    input  logic                      pop_valid_i,
    input  adma_xfer_pkg::desc_t      pop_desc_i,
    output logic                      pop_ready_o,
    output logic [`ADMA_ADDR_W-1:0]   m_araddr_o,
    output logic [7:0]                m_arlen_o,
    output logic                      m_arvalid_o,
    input  logic                      m_arready_i,
    input  logic [`ADMA_DATA_W-1:0]   m_rdata_i,
    input  adma_xfer_pkg::axi_resp_e  m_rresp_i,
    input  logic                      m_rlast_i,
    input  logic                      m_rvalid_i,
    output logic                      m_rready_o,
    output logic [`ADMA_DATA_W-1:0]   m_tdata_o,
    output logic                      m_tlast_o,
    output logic                      m_tvalid_o,
    input  logic                      m_tready_i,
    output logic                      xfer_done_o,
    output logic                      rd_err_o
);
    import adma_xfer_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]              state_q;
    logic [`ADMA_ADDR_W-1:0] addr_q;
    logic [`ADMA_LEN_W-1:0]  remain_q;
    logic [`ADMA_LEN_W-1:0]  burst_beats;
    logic                    last_burst_q;
    logic                    pop_hs;
    logic                    ar_hs;
    logic                    beat_hs;

    // New work is taken only when idle and enabled
    assign pop_ready_o = (state_q == ST_IDLE) && dma_en_i;
    assign pop_hs      = pop_valid_i && pop_ready_o;

    assign burst_beats = (remain_q > `ADMA_LEN_W'(`ADMA_MAX_BURST)) ?
                         `ADMA_LEN_W'(`ADMA_MAX_BURST) : remain_q;

    assign m_arvalid_o = (state_q == ST_ADDR);
    assign m_araddr_o  = addr_q;
    assign m_arlen_o   = 8'(burst_beats - 1'b1);
    assign ar_hs       = m_arvalid_o && m_arready_i;

    // R channel passes straight through to the stream
    assign m_tvalid_o  = (state_q == ST_DATA) && m_rvalid_i;
    assign m_rready_o  = (state_q == ST_DATA) && m_tready_i;
    assign m_tdata_o   = m_rdata_i;
    assign m_tlast_o   = m_tvalid_o && m_rlast_i && last_burst_q;
    assign beat_hs     = m_tvalid_o && m_tready_i;

    assign xfer_done_o = beat_hs && m_tlast_o;
    assign rd_err_o    = beat_hs && (m_rresp_i != OKAY);

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Zero length descriptors are dropped
                    if (pop_hs && pop_desc_i.len != '0) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (ar_hs) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (beat_hs && m_rlast_i) begin
                        state_q <= last_burst_q ? ST_IDLE : ST_ADDR;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Address advances by one data word per requested beat
    always_ff @(posedge aclk) begin
        if (pop_hs) begin
            addr_q   <= pop_desc_i.src_addr;
            remain_q <= pop_desc_i.len;
        end else if (ar_hs) begin
            addr_q       <= addr_q + `ADMA_ADDR_W'(burst_beats) * (`ADMA_DATA_W / 8);
            remain_q     <= remain_q - burst_beats;
            last_burst_q <= (remain_q == burst_beats);
        end
    end

    a_ar_hold: assert property (@(posedge aclk) disable iff (rst_i)
        m_arvalid_o && !m_arready_i |=>
            m_arvalid_o && $stable(m_araddr_o) && $stable(m_arlen_o));

    a_tlast_end: assert property (@(posedge aclk) disable iff (rst_i)
        m_tlast_o |-> m_tvalid_o && (remain_q == '0));

endmodule

//--- rtl/adma_top.sv
`timescale 1ns/1ns
`include "adma_macros.svh"

module adma_top (
    input  logic                      aclk,
    input  logic                      rst_i,
    // CSR port
    input  logic                      s_wvalid_i,
    input  logic [`ADMA_CSR_ADDR_W-1:0] s_waddr_i,
    input  adma_csr_pkg::csr_word_u   s_wdata_i,
    output logic                      s_wready_o,
    input  logic                      s_arvalid_i,
    input  logic [`ADMA_CSR_ADDR_W-1:0] s_araddr_i,
    output logic                      s_arready_o,
    output adma_csr_pkg::csr_word_u   s_rdata_o,
    output logic                      s_rvalid_o,
    input  logic                      s_rready_i,
    // AXI4 read source
    output logic [`ADMA_ADDR_W-1:0]   m_araddr_o,
    output logic [7:0]                m_arlen_o,
    output logic                      m_arvalid_o,
    input  logic                      m_arready_i,
    input  logic [`ADMA_DATA_W-1:0]   m_rdata_i,
    input  adma_xfer_pkg::axi_resp_e  m_rresp_i,
    input  logic                      m_rlast_i,
    input  logic                      m_rvalid_i,
    output logic                      m_rready_o,
    // AXI-Stream destination
    output logic [`ADMA_DATA_W-1:0]   m_tdata_o,
    output logic                      m_tlast_o,
    output logic                      m_tvalid_o,
    input  logic                      m_tready_i,
    output logic                      irq_o,
    output logic                      trap_o
);
    import adma_xfer_pkg::*;

    logic                              dma_en;
    logic                              push_valid;
    logic                              push_ready;
    desc_t                             push_desc;
    logic                              pop_valid;
    logic                              pop_ready;
    desc_t                             pop_desc;
    logic [$clog2(`ADMA_DESC_DEPTH):0] queue_level;
    logic                              xfer_done;
    logic                              rd_err;

    adma_reg_map rm (
        .aclk          (aclk),
        .rst_i         (rst_i),
        .s_wvalid_i    (s_wvalid_i),
        .s_waddr_i     (s_waddr_i),
        .s_wdata_i     (s_wdata_i),
        .s_wready_o    (s_wready_o),
        .s_arvalid_i   (s_arvalid_i),
        .s_araddr_i    (s_araddr_i),
        .s_arready_o   (s_arready_o),
        .s_rdata_o     (s_rdata_o),
        .s_rvalid_o    (s_rvalid_o),
        .s_rready_i    (s_rready_i),
        .push_valid_o  (push_valid),
        .push_ready_i  (push_ready),
        .push_desc_o   (push_desc),
        .queue_level_i (queue_level),
        .xfer_done_i   (xfer_done),
        .rd_err_i      (rd_err),
        .dma_en_o      (dma_en),
        .irq_o         (irq_o),
        .trap_o        (trap_o)
    );

    adma_desc_queue #(
        .DEPTH         (`ADMA_DESC_DEPTH)
    ) dq (
        .aclk          (aclk),
        .rst_i         (rst_i),
        .push_valid_i  (push_valid),
        .push_desc_i   (push_desc),
        .push_ready_o  (push_ready),
        .pop_valid_o   (pop_valid),
        .pop_desc_o    (pop_desc),
        .pop_ready_i   (pop_ready),
        .level_o       (queue_level)
    );

    adma_burst_mover bm (
        .aclk          (aclk),
        .rst_i         (rst_i),
        .dma_en_i      (dma_en),
        .pop_valid_i   (pop_valid),
        .pop_desc_i    (pop_desc),
        .pop_ready_o   (pop_ready),
        .m_araddr_o    (m_araddr_o),
        .m_arlen_o     (m_arlen_o),
        .m_arvalid_o   (m_arvalid_o),
        .m_arready_i   (m_arready_i),
        .m_rdata_i     (m_rdata_i),
        .m_rresp_i     (m_rresp_i),
        .m_rlast_i     (m_rlast_i),
        .m_rvalid_i    (m_rvalid_i),
        .m_rready_o    (m_rready_o),
        .m_tdata_o     (m_tdata_o),
        .m_tlast_o     (m_tlast_o),
        .m_tvalid_o    (m_tvalid_o),
        .m_tready_i    (m_tready_i),
        .xfer_done_o   (xfer_done),
        .rd_err_o      (rd_err)
    );

endmodule

//--- tests/adma_tb.sv
`timescale 1ns/1ns
`include "adma_macros.svh"

module adma_tb;
    import adma_csr_pkg::*;
    import adma_xfer_pkg::*;

    localparam logic [31:0] LCG_SEED = 32'hdce1_b0ce;
    localparam logic [31:0] MEM_KEY  = 32'h5a5a_a5a5;

    logic                        aclk;
    logic                        rst_i;
    logic                        s_wvalid_i;
    logic [`ADMA_CSR_ADDR_W-1:0] s_waddr_i;
    csr_word_u                   s_wdata_i;
    logic                        s_wready_o;
    logic                        s_arvalid_i;
    logic [`ADMA_CSR_ADDR_W-1:0] s_araddr_i;
    logic                        s_arready_o;
    csr_word_u                   s_rdata_o;
    logic                        s_rvalid_o;
    logic                        s_rready_i;
    logic [`ADMA_ADDR_W-1:0]     m_araddr_o;
    logic [7:0]                  m_arlen_o;
    logic                        m_arvalid_o;
    logic                        m_arready_i;
    logic [`ADMA_DATA_W-1:0]     m_rdata_i;
    axi_resp_e                   m_rresp_i;
    logic                        m_rlast_i;
    logic                        m_rvalid_i;
    logic                        m_rready_o;
    logic [`ADMA_DATA_W-1:0]     m_tdata_o;
    logic                        m_tlast_o;
    logic                        m_tvalid_o;
    logic                        m_tready_i;
    logic                        irq_o;
    logic                        trap_o;

    // Expected results in arrival order
    logic [`ADMA_DATA_W-1:0]     exp_data [$];
    logic                        exp_last [$];
    logic [`ADMA_ADDR_W-1:0]     exp_ar_addr [$];
    logic [7:0]                  exp_ar_len [$];
    logic [`ADMA_ADDR_W-1:0]     err_addrs [$];
    string                       stim_lines [$];

    logic [31:0]                 sink_rng = LCG_SEED;
    logic [31:0]                 mem_rng = ~LCG_SEED;
    logic [`ADMA_ADDR_W-1:0]     rd_addr;
    int                          rd_left = 0;
    logic                        r_hold;
    int                          err_idx;
    int                          cycle_cnt = 0;
    int                          cycle_limit = 1000;

    adma_top UUT (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            report_fail($sformatf("timeout after %0d cycles", cycle_cnt));
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int find_err(input logic [`ADMA_ADDR_W-1:0] addr);
        foreach (err_addrs[i]) begin
            if (err_addrs[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input logic [`ADMA_DATA_W-1:0] data, input logic last);
        logic [`ADMA_DATA_W-1:0] want_data;
        logic                    want_last;
        if (exp_data.size() == 0) begin
            report_fail("a stream beat arrived while no transfer was expected");
        end
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        if (data !== want_data || last !== want_last) begin
            report_fail($sformatf("FAIL %0t ns: stream beat %h last %b, expected %h last %b",
                                  $time, data, last, want_data, want_last));
        end
    endtask

    task automatic check_csr(input csr_word_u got, input csr_word_u want);
        if (got !== want) begin
            report_fail($sformatf("FAIL %0t ns: csr read %h, expected %h", $time, got, want));
        end
    endtask

    task automatic check_ar(input logic [`ADMA_ADDR_W-1:0] addr, input logic [7:0] len);
        logic [`ADMA_ADDR_W-1:0] want_addr;
        logic [7:0]              want_len;
        if (exp_ar_addr.size() == 0) begin
            report_fail("a read burst was requested while none was expected");
        end
        want_addr = exp_ar_addr.pop_front();
        want_len  = exp_ar_len.pop_front();
        if (addr !== want_addr || len !== want_len) begin
            report_fail($sformatf("FAIL %0t ns: AR addr %h len %0d, expected addr %h len %0d",
                                  $time, addr, len, want_addr, want_len));
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_fail($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, name, got, want));
        end
    endtask

    // Memory model for the AR and R channels
    always begin
        @(posedge aclk);
        r_hold = m_rvalid_i && !m_rready_o;
        if (m_rvalid_i && m_rready_o) begin
            if (m_rresp_i == SLVERR) begin
                err_idx = find_err(rd_addr);
                err_addrs.delete(err_idx);
            end
            rd_addr = rd_addr + 4;
            rd_left = rd_left - 1;
        end
        if (m_arvalid_o && m_arready_i) begin
            check_ar(m_araddr_o, m_arlen_o);
            rd_addr = m_araddr_o;
            rd_left = m_arlen_o + 1;
        end
        @(negedge aclk);
        mem_rng = lcg_step(mem_rng);
        m_arready_i = !rst_i && mem_rng[20];
        // Random gaps, but a presented beat holds until taken
        if (rd_left > 0 && (r_hold || mem_rng[23:22] != 2'b00)) begin
            m_rvalid_i = 1'b1;
            m_rdata_i  = rd_addr ^ MEM_KEY;
            m_rlast_i  = (rd_left == 1);
            m_rresp_i  = (find_err(rd_addr) >= 0) ? SLVERR : OKAY;
        end else begin
            m_rvalid_i = 1'b0;
            m_rlast_i  = 1'b0;
            m_rresp_i  = OKAY;
        end
    end

    // Stream sink with random back-pressure
    always begin
        @(posedge aclk);
        if (m_tvalid_o && m_tready_i) begin
            check_beat(m_tdata_o, m_tlast_o);
        end
        @(negedge aclk);
        sink_rng = lcg_step(sink_rng);
        m_tready_i = !rst_i && (sink_rng[19:18] != 2'b00);
    end

    task automatic csr_write(input logic [`ADMA_CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        s_wvalid_i = 1'b1;
        s_waddr_i  = addr;
        s_wdata_i  = data;
        do @(posedge aclk); while (!s_wready_o);
        @(negedge aclk);
        s_wvalid_i = 1'b0;
    endtask

    task automatic csr_read(input logic [`ADMA_CSR_ADDR_W-1:0] addr, output csr_word_u data);
        s_arvalid_i = 1'b1;
        s_araddr_i  = addr;
        do @(posedge aclk); while (!s_arready_o);
        @(negedge aclk);
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        do @(posedge aclk); while (!s_rvalid_o);
        data = s_rdata_o;
        @(negedge aclk);
        s_rready_i = 1'b0;
    endtask

    task automatic run_transfer(input logic [`ADMA_ADDR_W-1:0] src, input int beats,
                                input int err_beat);
        logic [`ADMA_ADDR_W-1:0] addr;
        int                      left;
        int                      chunk;
        int                      b;
        for (b = 0; b < beats; b++) begin
            exp_data.push_back((src + 4 * b) ^ MEM_KEY);
            exp_last.push_back(b == beats - 1);
        end
        // Bursts of up to 16 beats at rising addresses
        addr = src;
        left = beats;
        while (left > 0) begin
            chunk = (left > `ADMA_MAX_BURST) ? `ADMA_MAX_BURST : left;
            exp_ar_addr.push_back(addr);
            exp_ar_len.push_back(8'(chunk - 1));
            addr = addr + 4 * chunk;
            left = left - chunk;
        end
        if (err_beat >= 0) begin
            err_addrs.push_back(src + 4 * err_beat);
        end
        csr_write({SRC_ADDR, 2'b00}, src);
        csr_write({XFER_LEN, 2'b00}, beats);
    endtask

    // Length write against a full queue, withdrawn afterwards
    task automatic probe_full(input int cycles);
        s_wvalid_i = 1'b1;
        s_waddr_i  = {XFER_LEN, 2'b00};
        s_wdata_i  = 32'd1;
        repeat (cycles) begin
            @(posedge aclk);
            check_pin("s_wready_o", s_wready_o, 1'b0);
        end
        @(negedge aclk);
        s_wvalid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_data.size() != 0 || exp_ar_addr.size() != 0) begin
            @(negedge aclk);
        end
        // irq_o is one register behind the pending bit
        repeat (2) @(negedge aclk);
    endtask

    task automatic run_line(input string line);
        string       op;
        logic [31:0] a;
        logic [31:0] d;
        int          n;
        int          e;
        csr_word_u   got;
        void'($sscanf(line, "%s", op));
        if (op == "W") begin
            void'($sscanf(line, "%s %h %h", op, a, d));
            csr_write(a[`ADMA_CSR_ADDR_W-1:0], d);
        end else if (op == "R") begin
            void'($sscanf(line, "%s %h %h", op, a, d));
            csr_read(a[`ADMA_CSR_ADDR_W-1:0], got);
            check_csr(got, d);
        end else if (op == "T") begin
            void'($sscanf(line, "%s %h %d %d", op, a, n, e));
            run_transfer(a, n, e);
        end else if (op == "F") begin
            void'($sscanf(line, "%s %d", op, n));
            probe_full(n);
        end else if (op == "I") begin
            wait_idle();
        end else if (op == "P") begin
            void'($sscanf(line, "%s %d %d", op, n, e));
            repeat (2) @(negedge aclk);
            check_pin("irq_o", irq_o, n != 0);
            check_pin("trap_o", trap_o, e != 0);
        end else begin
            report_fail($sformatf("unknown opcode %s in the stimulus file", op));
        end
    endtask

    task automatic load_stim();
        int          fd;
        string       line;
        string       op;
        logic [31:0] a;
        int          beats;
        int          err_beat;
        int          total;
        total = 0;
        fd = $fopen("tests/adma_stim.txt", "r");
        if (fd == 0) begin
            report_fail("could not open tests/adma_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s", op) == 1 && line.getc(0) != "#") begin
                stim_lines.push_back(line);
                if (op == "T") begin
                    void'($sscanf(line, "%s %h %d %d", op, a, beats, err_beat));
                    total += beats;
                end
            end
        end
        $fclose(fd);
        cycle_limit = 1000 + 8 * total;
    endtask

    initial begin
        rst_i       = 1'b1;
        s_wvalid_i  = 1'b0;
        s_waddr_i   = '0;
        s_wdata_i   = '0;
        s_arvalid_i = 1'b0;
        s_araddr_i  = '0;
        s_rready_i  = 1'b0;
        m_arready_i = 1'b0;
        m_rdata_i   = '0;
        m_rresp_i   = OKAY;
        m_rlast_i   = 1'b0;
        m_rvalid_i  = 1'b0;
        m_tready_i  = 1'b0;
        load_stim();
        repeat (4) @(negedge aclk);
        rst_i = 1'b0;
        foreach (stim_lines[i]) begin
            run_line(stim_lines[i]);
        end
        if (exp_data.size() != 0 || exp_ar_addr.size() != 0) begin
            report_fail("the stimulus ended with transfers still outstanding");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- tests/adma_stim.txt
# op and operands: addresses and data in hex, counts in decimal
# W addr data | R addr expect | T src beats err_beat(-1 none) | F cycles | I | P irq trap
W 0 00000001
T 00001000 5 -1
I
R c 00000801
P 0 0
W c 00000800
T 00002000 37 -1
I
R c 00000802
W c 00000800
W 0 00000000
T 00003000 3 -1
T 00003100 2 -1
T 00003200 17 -1
T 00003300 1 -1
R c 00000402
F 6
W 0 00000001
T 00003400 4 -1
I
R c 00000807
W c 00000800
W 0 00000003
T 00004000 2 -1
I
P 1 0
W c 00000800
P 0 0
R c 00000008
T 00005000 6 2
I
P 1 1
R c 00001809
W c 00001800
P 0 0
R c 00000009
R 0 00000003
R 4 00005000

//--- adma_top.f
+incdir+rtl
rtl/adma_csr_pkg.sv
rtl/adma_xfer_pkg.sv
rtl/adma_reg_map.sv
rtl/adma_desc_queue.sv
rtl/adma_burst_mover.sv
rtl/adma_top.sv
tests/adma_tb.sv

//--- Bender.yml
package:
  name: adma

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/adma_csr_pkg.sv
      - rtl/adma_xfer_pkg.sv
      - rtl/adma_reg_map.sv
      - rtl/adma_desc_queue.sv
      - rtl/adma_burst_mover.sv
      - rtl/adma_top.sv
      - target: test
        include_dirs:
          - rtl
        files:
          - tests/adma_tb.sv
